//--- line_mapper.f
+incdir+logic
logic/map_types_pkg.sv
logic/bus_pkg.sv
logic/wb_regs.sv
logic/line_buffer.sv
logic/map_accumulator.sv
logic/pixel_counter.sv
logic/mapper_fsm.sv
logic/line_mapper.sv
tests/line_mapper_tb.sv

//--- logic/bus_pkg.sv
`default_nettype none
`include "mapper_cfg.svh"

package bus_pkg;

    typedef logic [15:0] wb_word_t;

    // control, kick in bit 0 on write, busy in bit 0 on read
    localparam logic [`WB_ADR_WIDTH-1:0] ADR_CTRL = 7'd0;

    // start position and step, both 8.8 fixed point
    localparam logic [`WB_ADR_WIDTH-1:0] ADR_ACCU_INIT = 7'd1;
    localparam logic [`WB_ADR_WIDTH-1:0] ADR_ACCU_BASE = 7'd2;

    // pixels per job
    localparam logic [`WB_ADR_WIDTH-1:0] ADR_LENGTH = 7'd3;

    // upper half of the map is the line buffer, write only
    localparam logic [`WB_ADR_WIDTH-1:0] ADR_LINE_BASE = 7'd64;

endpackage

`default_nettype wire

//--- logic/line_buffer.sv
`default_nettype none
`include "mapper_cfg.svh"

module line_buffer
    import map_types_pkg::*;
(
    input  wire           clk,
    input  wire           advance,
    input  wire           buf_we,
    input  wire s_index_t buf_wr_addr,
    input  wire sample_t  buf_wr_data,
    input  wire s_index_t rd_index,
    output sample_t       rd_sample
);

    sample_t mem [`MAP_LINE_SIZE];

    // host side
    always_ff @(posedge clk)
    begin
        if (buf_we)
        begin
            mem[buf_wr_addr] <= buf_wr_data;
        end
    end

    // mapping side, this register is the second pipeline stage
    always_ff @(posedge clk)
    begin
        if (advance)
        begin
            rd_sample <= mem[rd_index];
        end
    end

endmodule

`default_nettype wire

//--- logic/line_mapper.sv
`default_nettype none
`include "mapper_cfg.svh"

module line_mapper
    import map_types_pkg::*;
    import bus_pkg::*;
(
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire                      wb_cyc,
    input  wire                      wb_stb,
    input  wire                      wb_we,
    input  wire [`WB_ADR_WIDTH-1:0]  wb_adr,
    input  wire wb_word_t            wb_dat_w,
    output wb_word_t                 wb_dat_r,
    output logic                     wb_ack,
    output sample_t                  map_sample,
    output logic                     map_valid,
    input  wire                      map_ready
);

    logic      advance;
    logic      job_kick;
    logic      start;
    logic      issue;
    logic      busy;
    logic      last_pixel;
    logic      pipe_empty;
    map_accu_t accu_init;
    map_accu_t accu_base;
    wb_word_t  map_length;
    logic      buf_we;
    s_index_t  buf_wr_addr;
    sample_t   buf_wr_data;
    s_index_t  rd_index;
    sample_t   rd_sample;

    // the whole pipe moves unless a valid sample is being held back
    assign advance = map_ready || !map_valid;

    wb_regs u_wb_regs (
        .clk         (clk),
        .reset_n     (reset_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .busy        (busy),
        .job_kick    (job_kick),
        .accu_init   (accu_init),
        .accu_base   (accu_base),
        .map_length  (map_length),
        .buf_we      (buf_we),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_data (buf_wr_data)
    );

    line_buffer u_line_buffer (
        .clk         (clk),
        .advance     (advance),
        .buf_we      (buf_we),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_data (buf_wr_data),
        .rd_index    (rd_index),
        .rd_sample   (rd_sample)
    );

    map_accumulator u_map_accumulator (
        .clk        (clk),
        .reset_n    (reset_n),
        .start      (start),
        .issue      (issue),
        .advance    (advance),
        .accu_init  (accu_init),
        .accu_base  (accu_base),
        .rd_index   (rd_index),
        .rd_sample  (rd_sample),
        .pipe_empty (pipe_empty),
        .map_sample (map_sample),
        .map_valid  (map_valid)
    );

    pixel_counter u_pixel_counter (
        .clk        (clk),
        .reset_n    (reset_n),
        .start      (start),
        .issue      (issue),
        .map_length (map_length),
        .last_pixel (last_pixel)
    );

    mapper_fsm u_mapper_fsm (
        .clk        (clk),
        .reset_n    (reset_n),
        .job_kick   (job_kick),
        .advance    (advance),
        .last_pixel (last_pixel),
        .pipe_empty (pipe_empty),
        .start      (start),
        .issue      (issue),
        .busy       (busy)
    );

endmodule

`default_nettype wire

//--- logic/map_accumulator.sv
`default_nettype none
`include "mapper_cfg.svh"

module map_accumulator
    import map_types_pkg::*;
(
    input  wire             clk,
    input  wire             reset_n,
    input  wire             start,
    input  wire             issue,
    input  wire             advance,
    input  wire map_accu_t  accu_init,
    input  wire map_accu_t  accu_base,
    output s_index_t        rd_index,
    input  wire sample_t    rd_sample,
    output logic            pipe_empty,
    output sample_t         map_sample,
    output logic            map_valid
);

    map_accu_t pos;
    logic pos_oor;

    logic s1_valid;
    logic s1_oor;
    logic [`MAP_S_WIDTH-1:0] s1_s_val;

    logic s2_valid;
    logic s2_oor;

    // anything left of sample 0 or past the end of the line
    assign pos_oor = pos.fields.int_part < 0 || pos.fields.int_part >= `MAP_LINE_SIZE;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end
        else if (advance)
        begin
            s1_valid <= issue;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            pos <= accu_init;
        end
        else if (issue)
        begin
            // current position goes down the pipe before the step
            pos.raw <= pos.raw + accu_base.raw;
        end
        if (issue)
        begin
            s1_s_val <= pos.fields.int_part[`MAP_S_WIDTH-1:0];
            s1_oor <= pos_oor;
        end
        if (advance)
        begin
            s2_oor <= s1_oor;
        end
    end

    assign rd_index = s1_s_val[$bits(s_index_t)-1:0];

    assign map_sample = s2_oor ? '0 : rd_sample;
    assign map_valid = s2_valid;
    assign pipe_empty = !s1_valid && !s2_valid;

    s1_index_in_line: assert property (@(posedge clk) disable iff (!reset_n)
        s1_valid && !s1_oor |-> s1_s_val < `MAP_LINE_SIZE);

endmodule

`default_nettype wire

//--- logic/map_types_pkg.sv
`default_nettype none
`include "mapper_cfg.svh"

package map_types_pkg;

    // one accumulator word, seen whole or split at the binary point
    typedef union packed {
        logic signed [`MAP_ACCU_WIDTH-1:0] raw;
        struct packed {
            // two's complement, so this field is already the floor
            logic signed [`MAP_ACCU_WIDTH-`MAP_FRAC_BITS-1:0] int_part;
            logic        [`MAP_FRAC_BITS-1:0]                 frac;
        } fields;
    } map_accu_t;

    typedef logic signed [`MAP_SAMPLE_WIDTH-1:0] sample_t;

    // in-range address into the line buffer
    typedef logic [$clog2(`MAP_LINE_SIZE)-1:0] s_index_t;

endpackage

`default_nettype wire

//--- logic/mapper_cfg.svh
`ifndef MAPPER_CFG_SVH
`define MAPPER_CFG_SVH

// samples in one projection line
`define MAP_LINE_SIZE 64
// signed sample index, one bit wider than a buffer address
`define MAP_S_WIDTH 7

// accumulator is 8.8 fixed point
`define MAP_FRAC_BITS 8
`define MAP_ACCU_WIDTH 16

`define MAP_SAMPLE_WIDTH 16

// word address of the register and line buffer map
`define WB_ADR_WIDTH 7

`endif

//--- logic/mapper_fsm.sv
`default_nettype none

module mapper_fsm
(
    input  wire  clk,
    input  wire  reset_n,
    input  wire  job_kick,
    input  wire  advance,
    input  wire  last_pixel,
    input  wire  pipe_empty,
    output logic start,
    output logic issue,
    output logic busy
);

    localparam logic [1:0] idle_s = 2'd0;
    localparam logic [1:0] mapping_s = 2'd1;
    localparam logic [1:0] drain_s = 2'd2;

    logic [1:0] state;
    logic [1:0] next_state;

    assign start = state == idle_s && job_kick;
    // one pixel per pipeline advance
    assign issue = state == mapping_s && advance;
    assign busy = state != idle_s;

    always_comb
    begin
        next_state = state;
        case (state)
            idle_s:
                if (job_kick)
                begin
                    // zero length skips straight to drain
                    next_state = last_pixel ? drain_s : mapping_s;
                end
            mapping_s:
                if (issue && last_pixel)
                begin
                    next_state = drain_s;
                end
            drain_s:
                if (pipe_empty)
                begin
                    next_state = idle_s;
                end
            default:
                next_state = idle_s;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= idle_s;
        end
        else
        begin
            state <= next_state;
        end
    end

    // mapping ends with the last pixel, so no issue follows it
    no_issue_after_last: assert property (@(posedge clk) disable iff (!reset_n)
        issue && last_pixel |=> !issue);

endmodule

`default_nettype wire

//--- logic/pixel_counter.sv
`default_nettype none

module pixel_counter
    import bus_pkg::*;
(
    input  wire           clk,
    input  wire           reset_n,
    input  wire           start,
    input  wire           issue,
    input  wire wb_word_t map_length,
    output logic          last_pixel
);

    wb_word_t remaining;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            remaining <= '0;
        end
        else if (start)
        begin
            remaining <= map_length;
        end
        else if (issue)
        begin
            remaining <= remaining - 1'b1;
        end
    end

    // remaining is zero outside a job, so in idle this only flags a zero length
    assign last_pixel = remaining == 1 || map_length == 0;

endmodule

`default_nettype wire

//--- logic/wb_regs.sv
`default_nettype none
`include "mapper_cfg.svh"

module wb_regs
    import map_types_pkg::*;
    import bus_pkg::*;
(
    input  wire                      clk,
    input  wire                      reset_n,
    input  wire                      wb_cyc,
    input  wire                      wb_stb,
    input  wire                      wb_we,
    input  wire [`WB_ADR_WIDTH-1:0]  wb_adr,
    input  wire wb_word_t            wb_dat_w,
    output wb_word_t                 wb_dat_r,
    output logic                     wb_ack,
    input  wire                      busy,
    output logic                     job_kick,
    output map_accu_t                accu_init,
    output map_accu_t                accu_base,
    output wb_word_t                 map_length,
    output logic                     buf_we,
    output s_index_t                 buf_wr_addr,
    output sample_t                  buf_wr_data
);

    logic req;
    logic held;
    logic take;
    logic wr_take;
    logic in_window;

    assign req = wb_cyc && wb_stb;
    // new transfer only, never the tail of one already acked
    assign take = req && !wb_ack && !held;
    assign wr_take = take && wb_we;
    assign in_window = wb_adr >= ADR_LINE_BASE;

    // line buffer writes land on the same edge the ack is raised
    assign buf_we = wr_take && in_window;
    assign buf_wr_addr = wb_adr[$bits(s_index_t)-1:0];
    assign buf_wr_data = wb_dat_w;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wb_ack <= 1'b0;
            held <= 1'b0;
            job_kick <= 1'b0;
        end
        else
        begin
            wb_ack <= take;
            // set after an ack, cleared once the master lets go
            held <= req && (held || wb_ack);
            job_kick <= wr_take && !busy && wb_adr == ADR_CTRL && wb_dat_w[0];
        end
    end

    // job registers stay frozen while a job runs
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            accu_init <= '0;
            accu_base <= '0;
            map_length <= '0;
        end
        else if (wr_take && !busy)
        begin
            case (wb_adr)
                ADR_ACCU_INIT: accu_init.raw <= wb_dat_w;
                ADR_ACCU_BASE: accu_base.raw <= wb_dat_w;
                ADR_LENGTH:    map_length <= wb_dat_w;
                default:       ;
            endcase
        end
    end

    // read data lines up with the ack
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            case (wb_adr)
                ADR_CTRL:      wb_dat_r <= wb_word_t'(busy);
                ADR_ACCU_INIT: wb_dat_r <= accu_init.raw;
                ADR_ACCU_BASE: wb_dat_r <= accu_base.raw;
                ADR_LENGTH:    wb_dat_r <= map_length;
                // line buffer window and holes read as zero
                default:       wb_dat_r <= '0;
            endcase
        end
    end

    ack_needs_stb: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(wb_ack) |-> $past(wb_stb));

endmodule

`default_nettype wire

//--- tests/line_mapper_tb.sv
`default_nettype none
`include "mapper_cfg.svh"

module line_mapper_tb
    import map_types_pkg::*;
    import bus_pkg::*;
();

    localparam int ACK_TIMEOUT = 20;
    localparam int IDLE_POLLS = 200;
    localparam int STREAM_TIMEOUT = 2000;

    logic                     clk;
    logic                     reset_n;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [`WB_ADR_WIDTH-1:0] wb_adr;
    wb_word_t                 wb_dat_w;
    wb_word_t                 wb_dat_r;
    logic                     wb_ack;
    sample_t                  map_sample;
    logic                     map_valid;
    logic                     map_ready;

    logic [31:0] lfsr;
    sample_t     line_samples [`MAP_LINE_SIZE];
    sample_t     expected [$];
    logic        job_done;
    int          fd;

    line_mapper dut (
        .clk        (clk),
        .reset_n    (reset_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .map_sample (map_sample),
        .map_valid  (map_valid),
        .map_ready  (map_ready)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t want);
        if (got !== want)
        begin
            report_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                     $time, name, got, want));
        end
    endtask

    task automatic check_word(input string name, input wb_word_t got, input wb_word_t want);
        if (got !== want)
        begin
            report_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                     $time, name, got, want));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic random_bit(output logic b);
        lfsr = lfsr_step(lfsr);
        b = lfsr[0];
    endtask

    // called one unit after a rising edge, returns at the same phase
    task automatic bus_cycle(input logic we, input logic [`WB_ADR_WIDTH-1:0] adr,
                             input wb_word_t wdata, output wb_word_t rdata);
        int waited;
        waited = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = wdata;
        @(posedge clk);
        #1;
        while (!wb_ack)
        begin
            waited++;
            if (waited > ACK_TIMEOUT)
            begin
                report_failure($sformatf("no Wishbone ack for address %0d", adr));
            end
            @(posedge clk);
            #1;
        end
        rdata = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        // idle cycle so the next request counts as new
        @(posedge clk);
        #1;
        if (wb_ack)
        begin
            report_failure("wb_ack stayed high for more than one cycle");
        end
    endtask

    task automatic bus_write(input logic [`WB_ADR_WIDTH-1:0] adr, input wb_word_t data);
        wb_word_t unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(input logic [`WB_ADR_WIDTH-1:0] adr, output wb_word_t data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    task automatic wait_idle();
        int polls;
        wb_word_t status;
        polls = 0;
        bus_read(ADR_CTRL, status);
        while (status[0])
        begin
            polls++;
            if (polls > IDLE_POLLS)
            begin
                report_failure("busy never cleared after the job");
            end
            bus_read(ADR_CTRL, status);
        end
        check_word("ctrl after job", status, 16'h0000);
    endtask

    // watches every cycle until the job is done and all samples are in
    task automatic collect_stream(input logic random_ready, input int len);
        int count;
        int cycles;
        logic stalled;
        logic ready_bit;
        sample_t held;
        count = 0;
        cycles = 0;
        stalled = 1'b0;
        held = '0;
        while (count < len || !job_done)
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > STREAM_TIMEOUT)
            begin
                report_failure($sformatf("stream timed out after %0d of %0d samples",
                                         count, len));
            end
            if (stalled)
            begin
                if (!map_valid)
                begin
                    report_failure("map_valid dropped while the sink stalled");
                end
                check_sample("map_sample while stalled", map_sample, held);
            end
            if (random_ready)
            begin
                random_bit(ready_bit);
                map_ready = ready_bit;
            end
            else
            begin
                map_ready = 1'b1;
            end
            if (map_valid && count >= len)
            begin
                report_failure("map_valid raised after the last pixel of the job");
            end
            if (map_valid && map_ready)
            begin
                check_sample($sformatf("map_sample[%0d]", count), map_sample, expected[count]);
                count++;
            end
            stalled = map_valid && !map_ready;
            held = map_sample;
        end
        map_ready = 1'b1;
    endtask

    // next line that is not blank or a comment
    task automatic read_record(output logic found, output string text);
        int code;
        found = 1'b0;
        text = "";
        while (!found && !$feof(fd))
        begin
            code = $fgets(text, fd);
            if (code > 0 && text.len() > 0 && text[0] != "#" && text[0] != "\n"
                && text[0] != "\r")
            begin
                found = 1'b1;
            end
        end
    endtask

    task automatic load_line();
        logic found;
        string text;
        wb_word_t w [8];
        int n;
        for (int r = 0; r < `MAP_LINE_SIZE / 8; r++)
        begin
            read_record(found, text);
            if (!found)
            begin
                report_failure("vector file ends inside the line samples");
            end
            n = $sscanf(text, "%h %h %h %h %h %h %h %h",
                        w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
            if (n != 8)
            begin
                report_failure("malformed line sample record in the vector file");
            end
            for (int k = 0; k < 8; k++)
            begin
                line_samples[r * 8 + k] = w[k];
            end
        end
    endtask

    task automatic run_job(input string job_text);
        logic found;
        string text;
        wb_word_t init;
        wb_word_t base;
        wb_word_t len;
        wb_word_t mode;
        wb_word_t e [4];
        wb_word_t rd;
        if ($sscanf(job_text, "%h %h %h %h", init, base, len, mode) != 4)
        begin
            report_failure("malformed job record in the vector file");
        end
        if (len % 4 != 0)
        begin
            report_failure("job length in the vector file is not a multiple of four");
        end
        expected.delete();
        for (int r = 0; r < len / 4; r++)
        begin
            read_record(found, text);
            if (!found || $sscanf(text, "%h %h %h %h", e[0], e[1], e[2], e[3]) != 4)
            begin
                report_failure("missing or malformed expected samples in the vector file");
            end
            for (int k = 0; k < 4; k++)
            begin
                expected.push_back(e[k]);
            end
        end

        bus_write(ADR_ACCU_INIT, init);
        bus_write(ADR_ACCU_BASE, base);
        bus_write(ADR_LENGTH, len);
        bus_read(ADR_ACCU_INIT, rd);
        check_word("accu_init readback", rd, init);
        bus_read(ADR_ACCU_BASE, rd);
        check_word("accu_base readback", rd, base);
        bus_read(ADR_LENGTH, rd);
        check_word("map_length readback", rd, len);
        bus_read(ADR_CTRL, rd);
        check_word("ctrl before kick", rd, 16'h0000);

        job_done = 1'b0;
        fork
            collect_stream(mode[0], int'(len));
            begin
                bus_write(ADR_CTRL, 16'h0001);
                if (len != 0)
                begin
                    bus_read(ADR_CTRL, rd);
                    check_word("ctrl during job", rd, 16'h0001);
                    // must be dropped while busy
                    bus_write(ADR_ACCU_BASE, ~base);
                end
                wait_idle();
                job_done = 1'b1;
            end
        join
        bus_read(ADR_ACCU_BASE, rd);
        check_word("accu_base after job", rd, base);
    endtask

    initial
    begin
        wb_word_t rd;
        logic found;
        string text;
        int jobs;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        map_ready = 1'b1;
        reset_n = 1'b0;
        lfsr = 32'h8888;
        job_done = 1'b0;
        jobs = 0;

        fd = $fopen("tests/line_mapper_vectors.txt", "r");
        if (fd == 0)
        begin
            report_failure("cannot open tests/line_mapper_vectors.txt");
        end
        load_line();

        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b1;
        if (map_valid || wb_ack)
        begin
            report_failure("map_valid or wb_ack high after reset");
        end

        for (int i = 0; i < `MAP_LINE_SIZE; i++)
        begin
            bus_write(ADR_LINE_BASE + i, line_samples[i]);
        end
        // window is write only
        bus_read(ADR_LINE_BASE + 5, rd);
        check_word("line window readback", rd, 16'h0000);
        bus_read(ADR_LINE_BASE + 63, rd);
        check_word("line window readback", rd, 16'h0000);

        read_record(found, text);
        while (found)
        begin
            run_job(text);
            jobs++;
            read_record(found, text);
        end
        $fclose(fd);
        if (jobs == 0)
        begin
            report_failure("vector file holds no jobs");
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/line_mapper_vectors.txt
# line samples: 64 hex words, eight per line, from buffer index 0 upward
# jobs: init base length ready_mode (1 = random ready), then expected samples four per line
5a00 5a01 5a02 5a03 5a04 5a05 5a06 5a07
5a08 5a09 5a0a 5a0b 5a0c 5a0d 5a0e 5a0f
5a10 5a11 5a12 5a13 5a14 5a15 5a16 5a17
5a18 5a19 5a1a 5a1b 5a1c 5a1d 5a1e 5a1f
a520 a521 a522 a523 a524 a525 a526 a527
a528 a529 a52a a52b a52c a52d a52e a52f
a530 a531 a532 a533 a534 a535 a536 a537
a538 a539 a53a a53b a53c a53d a53e a53f
# forward from 2.5 in steps of 1.25
0280 0140 0008 0
5a02 5a03 5a05 5a06
5a07 5a08 5a0a 5a0b
# starts at -3.0 and runs past the end of the line
fd00 0c80 0008 0
0000 5a09 5a16 a522
a52f a53b 0000 0000
# -0.5 floors to -1
ff80 0180 000c 1
0000 5a01 5a02 5a04
5a05 5a07 5a08 5a0a
5a0b 5a0d 5a0e 5a10
# backward from 63.25 in steps of -7.0
3f40 f900 000c 1
a53f a538 a531 a52a
a523 5a1c 5a15 5a0e
5a07 5a00 0000 0000
# zero length
0000 0100 0000 0
